// File: pio_ingress_adapter.f
+incdir+tb
verilog/pio_pkg.sv
verilog/pio_regs.sv
verilog/byte_splitter.sv
verilog/beat_fifo.sv
verilog/stream_throttle.sv
verilog/pio_ingress_adapter.sv
tb/pio_ingress_adapter_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       := pio_ingress_adapter_tb
FILELIST  := pio_ingress_adapter.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/pio_tb_ref.svh
`ifndef PIO_TB_REF_SVH
`define PIO_TB_REF_SVH

// galois lfsr state, one step per random bit
logic [31:0] lfsr_state = 32'hbc7ffcea;

// expected beats, {data, last}
logic [8:0] exp_q [$];

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        r = {r[30:0], lsb};
    end
    return r;
endfunction

// kept bytes in ascending order, last only on the final kept one
function automatic logic [35:0] split_ref(input logic [31:0] w, input logic [3:0] k,
                                          input logic l, output int n);
    logic [35:0] r;
    int          last_i;
    r = '0;
    n = 0;
    last_i = -1;
    for (int i = 0; i < 4; i++) begin
        if (k[i]) begin
            last_i = i;
        end
    end
    for (int i = 0; i < 4; i++) begin
        if (k[i]) begin
            r[n * 9 +: 9] = {w[i * 8 +: 8], l && (i == last_i)};
            n++;
        end
    end
    return r;
endfunction

task automatic push_expected(input logic [31:0] w, input logic [3:0] k, input logic l);
    logic [35:0] beats;
    int          n;
    beats = split_ref(w, k, l, n);
    for (int i = 0; i < n; i++) begin
        exp_q.push_back(beats[i * 9 +: 9]);
    end
endtask

`endif

// File: tb/pio_ingress_adapter_tb.sv
`timescale 1ns/1ps

module pio_ingress_adapter_tb;

    `include "pio_tb_ref.svh"

    // 28 words in all tests
    localparam int TOTAL_WORDS = 28;
    localparam int LIMIT_CYCLES = TOTAL_WORDS * 4 * 8 + 2000;

    logic        clk;
    logic        rst;
    logic        ctrl_wen;
    logic [31:0] ctrl_waddr;
    logic [31:0] ctrl_wdata;
    logic        ctrl_ren;
    logic [31:0] ctrl_raddr;
    logic [31:0] ctrl_rdata;
    logic        stream_valid;
    logic [7:0]  stream_data;
    logic        stream_last;
    logic        stream_empty;
    logic        stream_ready;

    logic        ready_random;
    logic [3:0]  cur_keep;
    logic        cur_last;
    logic [31:0] exp_credit;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          data_seen;
    int          null_seen;

    pio_ingress_adapter uut (
        .clk          (clk),
        .rst          (rst),
        .ctrl_wen     (ctrl_wen),
        .ctrl_waddr   (ctrl_waddr),
        .ctrl_wdata   (ctrl_wdata),
        .ctrl_ren     (ctrl_ren),
        .ctrl_raddr   (ctrl_raddr),
        .ctrl_rdata   (ctrl_rdata),
        .stream_valid (stream_valid),
        .stream_data  (stream_data),
        .stream_last  (stream_last),
        .stream_empty (stream_empty),
        .stream_ready (stream_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        if (ready_random) begin
            stream_ready = rand_bits(1) != 0;
        end else begin
            stream_ready = 1'b1;
        end
    end

    // compares every accepted beat with the expected queue
    always @(posedge clk) begin
        logic [8:0] exp;
        logic       data_beat;
        data_beat = 1'b0;
        if (rst) begin
            exp_credit = '0;
        end else begin
            if (stream_valid && stream_ready) begin
                if (stream_empty) begin
                    null_seen++;
                    assert (exp_q.size() == 0 || exp_credit == 0) else begin
                        $display("null beat sent while a data beat was due");
                        errors++;
                    end
                    assert (stream_last == 1'b0) else begin
                        $display("error stream_last got 0x%h expected 0x0", stream_last);
                        errors++;
                    end
                end else begin
                    data_beat = 1'b1;
                    data_seen++;
                    assert (exp_credit != 0) else begin
                        $display("data beat sent with the data count exhausted");
                        errors++;
                    end
                    assert (exp_q.size() != 0) else begin
                        $display("data beat 0x%h sent with nothing expected", stream_data);
                        errors++;
                    end
                    if (exp_q.size() != 0) begin
                        exp = exp_q.pop_front();
                        assert (stream_data == exp[8:1]) else begin
                            $display("error stream_data got 0x%h expected 0x%h",
                                     stream_data, exp[8:1]);
                            errors++;
                        end
                        assert (stream_last == exp[0]) else begin
                            $display("error stream_last got 0x%h expected 0x%h",
                                     stream_last, exp[0]);
                            errors++;
                        end
                    end
                end
            end
            // data credit, a load wins over a decrement
            if (ctrl_wen && ctrl_waddr == 32'h08) begin
                exp_credit = ctrl_wdata;
            end else if (data_beat && exp_credit != 0) begin
                exp_credit = exp_credit - 32'd1;
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", LIMIT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        ctrl_wen = 1'b1;
        ctrl_waddr = addr;
        ctrl_wdata = data;
        @(negedge clk);
        ctrl_wen = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        ctrl_ren = 1'b1;
        ctrl_raddr = addr;
        #1;
        data = ctrl_rdata;
        ctrl_ren = 1'b0;
    endtask

    task automatic check_reg(input logic [31:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] got;
        read_reg(addr, got);
        assert (got == exp) else begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic set_ctrl(input logic en, input logic [3:0] keep, input logic last,
                            input logic clear);
        cur_keep = keep;
        cur_last = last;
        write_reg(32'h00, {23'd0, last, keep, 2'd0, clear, en});
    endtask

    // polls status bit 0 before each data-in write
    task automatic write_word(input logic [31:0] w);
        logic [31:0] st;
        st = '0;
        while (st[0] == 1'b0) begin
            read_reg(32'h04, st);
        end
        push_expected(w, cur_keep, cur_last);
        write_reg(32'h04, w);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = '0;
        while (st[0] == 1'b0) begin
            read_reg(32'h04, st);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            assert (!stream_valid) else begin
                $display("stream_valid went high while the output should be idle");
                errors++;
            end
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        assert (got == exp) else begin
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        test_errors = errors;
    endtask

    initial begin
        int d0;
        int n0;
        rst = 1'b1;
        ctrl_wen = 1'b0;
        ctrl_waddr = '0;
        ctrl_wdata = '0;
        ctrl_ren = 1'b0;
        ctrl_raddr = '0;
        stream_ready = 1'b0;
        ready_random = 1'b0;
        cur_keep = 4'hF;
        cur_last = 1'b0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        data_seen = 0;
        null_seen = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reg(32'h00, 32'h0000_00F0, "ctrl");
        check_reg(32'h04, 32'h1, "status");
        check_reg(32'h08, 32'h0, "data_cnt");
        check_reg(32'h0C, 32'h0, "null_cnt");
        expect_quiet(10);
        end_test("reset");

        // random words, keep masks and last flags
        ready_random = 1'b1;
        write_reg(32'h08, 32'h0000_FFFF);
        for (int i = 0; i < 20; i++) begin
            set_ctrl(1'b1, 4'(rand_bits(4)), rand_bits(1) != 0, 1'b0);
            write_word(rand_bits(32));
        end
        drain();
        ready_random = 1'b0;
        end_test("data_path");

        write_reg(32'h08, 32'h0);
        set_ctrl(1'b1, 4'hF, 1'b0, 1'b0);
        d0 = data_seen;
        for (int i = 0; i < 3; i++) begin
            write_word(rand_bits(32));
        end
        wait_idle();
        write_reg(32'h08, 32'd5);
        while (data_seen - d0 < 5) begin
            @(posedge clk);
        end
        expect_quiet(20);
        check_count(data_seen - d0, 5, "data beats");
        check_reg(32'h08, 32'h0, "data_cnt");
        end_test("throttle");

        // leftover bytes are flushed
        set_ctrl(1'b1, 4'hF, 1'b0, 1'b1);
        exp_q.delete();
        write_reg(32'h08, 32'h0000_FFFF);
        expect_quiet(20);
        check_reg(32'h04, 32'h1, "status");
        set_ctrl(1'b1, 4'h6, 1'b1, 1'b0);
        write_word(rand_bits(32));
        drain();
        end_test("clear");

        n0 = null_seen;
        write_reg(32'h0C, 32'd6);
        while (null_seen - n0 < 6) begin
            @(posedge clk);
        end
        expect_quiet(20);
        check_count(null_seen - n0, 6, "null beats");
        set_ctrl(1'b0, 4'hF, 1'b1, 1'b0);
        write_word(rand_bits(32));
        write_word(rand_bits(32));
        wait_idle();
        write_reg(32'h0C, 32'd5);
        n0 = null_seen;
        set_ctrl(1'b1, 4'hF, 1'b0, 1'b0);
        drain();
        while (null_seen - n0 < 5) begin
            @(posedge clk);
        end
        expect_quiet(20);
        check_count(null_seen - n0, 5, "null beats");
        check_reg(32'h0C, 32'h0, "null_cnt");
        end_test("null_priority");

        set_ctrl(1'b0, 4'hB, 1'b1, 1'b0);
        write_reg(32'h0C, 32'd3);
        write_word(rand_bits(32));
        write_word(rand_bits(32));
        expect_quiet(30);
        n0 = null_seen;
        set_ctrl(1'b1, 4'hB, 1'b1, 1'b0);
        drain();
        while (null_seen - n0 < 3) begin
            @(posedge clk);
        end
        expect_quiet(20);
        check_count(null_seen - n0, 3, "null beats");
        end_test("enable");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/pio_ingress_adapter.sv
`timescale 1ns/1ps

module pio_ingress_adapter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ctrl_wen,
    input  logic [pio_pkg::ADDR_WIDTH-1:0] ctrl_waddr,
    input  logic [pio_pkg::WORD_WIDTH-1:0] ctrl_wdata,
    input  logic                           ctrl_ren,
    input  logic [pio_pkg::ADDR_WIDTH-1:0] ctrl_raddr,
    output logic [pio_pkg::WORD_WIDTH-1:0] ctrl_rdata,
    output logic                           stream_valid,
    output logic [pio_pkg::BEAT_WIDTH-1:0] stream_data,
    output logic                           stream_last,
    output logic                           stream_empty,
    input  logic                           stream_ready
);

    logic                           word_valid;
    logic                           word_ready;
    pio_pkg::in_word_t              word;
    logic                           enable;
    logic                           buffer_clear;
    logic                           data_cnt_load;
    logic                           null_cnt_load;
    logic [pio_pkg::WORD_WIDTH-1:0] load_value;
    logic [pio_pkg::WORD_WIDTH-1:0] data_cnt;
    logic [pio_pkg::WORD_WIDTH-1:0] null_cnt;

    // splitter to fifo
    logic                           split_valid;
    logic                           split_ready;
    pio_pkg::out_beat_t             split_beat;

    // fifo to throttle
    logic                           fifo_valid;
    logic                           fifo_ready;
    pio_pkg::out_beat_t             fifo_beat;

    pio_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .ctrl_wen      (ctrl_wen),
        .ctrl_waddr    (ctrl_waddr),
        .ctrl_wdata    (ctrl_wdata),
        .ctrl_ren      (ctrl_ren),
        .ctrl_raddr    (ctrl_raddr),
        .ctrl_rdata    (ctrl_rdata),
        .word_valid    (word_valid),
        .word          (word),
        .word_ready    (word_ready),
        .enable        (enable),
        .buffer_clear  (buffer_clear),
        .data_cnt_load (data_cnt_load),
        .null_cnt_load (null_cnt_load),
        .load_value    (load_value),
        .data_cnt      (data_cnt),
        .null_cnt      (null_cnt)
    );

    byte_splitter u_splitter (
        .clk        (clk),
        .rst        (rst),
        .clear      (buffer_clear),
        .word_valid (word_valid),
        .word       (word),
        .word_ready (word_ready),
        .beat_valid (split_valid),
        .beat       (split_beat),
        .beat_ready (split_ready)
    );

    beat_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .clear     (buffer_clear),
        .in_valid  (split_valid),
        .in_ready  (split_ready),
        .in_beat   (split_beat),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_beat  (fifo_beat)
    );

    stream_throttle u_throttle (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .data_cnt_load (data_cnt_load),
        .null_cnt_load (null_cnt_load),
        .load_value    (load_value),
        .data_cnt      (data_cnt),
        .null_cnt      (null_cnt),
        .fifo_valid    (fifo_valid),
        .fifo_ready    (fifo_ready),
        .fifo_beat     (fifo_beat),
        .stream_valid  (stream_valid),
        .stream_data   (stream_data),
        .stream_last   (stream_last),
        .stream_empty  (stream_empty),
        .stream_ready  (stream_ready)
    );

endmodule

// File: verilog/stream_throttle.sv
`timescale 1ns/1ps

module stream_throttle (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,
    input  logic                           data_cnt_load,
    input  logic                           null_cnt_load,
    input  logic [pio_pkg::WORD_WIDTH-1:0] load_value,
    output logic [pio_pkg::WORD_WIDTH-1:0] data_cnt,
    output logic [pio_pkg::WORD_WIDTH-1:0] null_cnt,
    input  logic                           fifo_valid,
    output logic                           fifo_ready,
    input  pio_pkg::out_beat_t             fifo_beat,
    output logic                           stream_valid,
    output logic [pio_pkg::BEAT_WIDTH-1:0] stream_data,
    output logic                           stream_last,
    output logic                           stream_empty,
    input  logic                           stream_ready
);

    logic data_credit;
    logic data_valid;
    logic null_valid;
    logic data_take;
    logic null_take;

    // data beats need both a buffered byte and data credit
    assign data_credit = data_cnt != '0;
    assign data_valid = fifo_valid && data_credit;
    assign null_valid = null_cnt != '0;

    // data wins over null
    assign stream_valid = enable && (data_valid || null_valid);
    assign stream_data = fifo_beat.data;
    assign stream_last = data_valid && fifo_beat.last;
    assign stream_empty = !data_valid;

    assign fifo_ready = enable && stream_ready && data_credit;

    assign data_take = enable && stream_ready && data_valid;
    assign null_take = enable && stream_ready && null_valid && !data_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_cnt <= '0;
        end else if (data_cnt_load) begin
            data_cnt <= load_value;
        end else if (data_take) begin
            data_cnt <= data_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            null_cnt <= '0;
        end else if (null_cnt_load) begin
            null_cnt <= load_value;
        end else if (null_take) begin
            null_cnt <= null_cnt - 1'b1;
        end
    end

endmodule

// File: verilog/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               in_valid,
    output logic               in_ready,
    input  pio_pkg::out_beat_t in_beat,
    output logic               out_valid,
    input  logic               out_ready,
    output pio_pkg::out_beat_t out_beat
);

    pio_pkg::out_beat_t mem [pio_pkg::FIFO_DEPTH];

    logic [pio_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [pio_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [pio_pkg::FIFO_CNT_WIDTH-1:0] count;
    logic                               push;
    logic                               pop;

    assign in_ready = count != pio_pkg::FIFO_CNT_WIDTH'(pio_pkg::FIFO_DEPTH);
    assign out_valid = count != '0;
    assign out_beat = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == pio_pkg::FIFO_PTR_WIDTH'(pio_pkg::FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == pio_pkg::FIFO_PTR_WIDTH'(pio_pkg::FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

endmodule

// File: verilog/byte_splitter.sv
`timescale 1ns/1ps

module byte_splitter (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               word_valid,
    input  pio_pkg::in_word_t  word,
    output logic               word_ready,
    output logic               beat_valid,
    output pio_pkg::out_beat_t beat,
    input  logic               beat_ready
);

    logic                               busy;
    logic [pio_pkg::WORD_BYTES-1:0]     keep_rem;
    logic [pio_pkg::WORD_BYTES-1:0]     low_bit;
    logic [pio_pkg::WORD_BYTES-1:0]     rest;
    logic [pio_pkg::WORD_SEL_WIDTH-1:0] sel;
    logic [pio_pkg::WORD_WIDTH-1:0]     data_q;
    logic                               last_q;

    assign word_ready = !busy;

    // lowest remaining kept byte
    assign low_bit = keep_rem & (~keep_rem + 1'b1);
    assign rest = keep_rem & ~low_bit;

    always_comb begin
        sel = '0;
        for (int i = pio_pkg::WORD_BYTES - 1; i >= 0; i--) begin
            if (keep_rem[i]) begin
                sel = pio_pkg::WORD_SEL_WIDTH'(i);
            end
        end
    end

    assign beat_valid = busy && (keep_rem != '0);

    always_comb begin
        beat.data = data_q[sel * pio_pkg::BEAT_WIDTH +: pio_pkg::BEAT_WIDTH];
        // last only on the final kept byte
        beat.last = last_q && (rest == '0);
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            busy <= 1'b0;
            keep_rem <= '0;
        end else if (!busy) begin
            if (word_valid) begin
                busy <= 1'b1;
                keep_rem <= word.keep;
            end
        end else if (keep_rem == '0) begin
            // empty keep mask, word absorbed with no beats
            busy <= 1'b0;
        end else if (beat_ready) begin
            keep_rem <= rest;
            if (rest == '0) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && word_ready) begin
            data_q <= word.data;
            last_q <= word.last;
        end
    end

endmodule

// File: verilog/pio_regs.sv
`timescale 1ns/1ps

module pio_regs (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           ctrl_wen,
    input  logic [pio_pkg::ADDR_WIDTH-1:0] ctrl_waddr,
    input  logic [pio_pkg::WORD_WIDTH-1:0] ctrl_wdata,
    input  logic                           ctrl_ren,
    input  logic [pio_pkg::ADDR_WIDTH-1:0] ctrl_raddr,
    output logic [pio_pkg::WORD_WIDTH-1:0] ctrl_rdata,
    output logic                           word_valid,
    output pio_pkg::in_word_t              word,
    input  logic                           word_ready,
    output logic                           enable,
    output logic                           buffer_clear,
    output logic                           data_cnt_load,
    output logic                           null_cnt_load,
    output logic [pio_pkg::WORD_WIDTH-1:0] load_value,
    input  logic [pio_pkg::WORD_WIDTH-1:0] data_cnt,
    input  logic [pio_pkg::WORD_WIDTH-1:0] null_cnt
);

    logic                           wr_ctrl;
    logic                           wr_data;
    logic [pio_pkg::WORD_BYTES-1:0] keep;
    logic                           last;
    logic [pio_pkg::WORD_WIDTH-1:0] ctrl_word;
    logic [pio_pkg::WORD_WIDTH-1:0] stat_word;

    // one-hot write strobes from address bits 3:2
    always_comb begin
        wr_ctrl = 1'b0;
        wr_data = 1'b0;
        data_cnt_load = 1'b0;
        null_cnt_load = 1'b0;
        if (ctrl_wen) begin
            case (ctrl_waddr[3:2])
                pio_pkg::REG_CTRL[3:2]:     wr_ctrl = 1'b1;
                pio_pkg::REG_DATA[3:2]:     wr_data = 1'b1;
                pio_pkg::REG_DATA_CNT[3:2]: data_cnt_load = 1'b1;
                pio_pkg::REG_NULL_CNT[3:2]: null_cnt_load = 1'b1;
                default:                    wr_ctrl = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= pio_pkg::CTRL_RESET_VALUE[pio_pkg::CTRL_ENABLE];
            keep <= pio_pkg::CTRL_RESET_VALUE[pio_pkg::CTRL_KEEP_LSB +: pio_pkg::WORD_BYTES];
            last <= pio_pkg::CTRL_RESET_VALUE[pio_pkg::CTRL_LAST];
        end else if (wr_ctrl) begin
            enable <= ctrl_wdata[pio_pkg::CTRL_ENABLE];
            keep <= ctrl_wdata[pio_pkg::CTRL_KEEP_LSB +: pio_pkg::WORD_BYTES];
            last <= ctrl_wdata[pio_pkg::CTRL_LAST];
        end
    end

    // clear bit is a pulse, never stored
    assign buffer_clear = wr_ctrl && ctrl_wdata[pio_pkg::CTRL_CLEAR];

    // data-in word takes keep and last from the control register
    always_comb begin
        word.data = ctrl_wdata;
        word.keep = keep;
        word.last = last;
    end

    assign word_valid = wr_data;
    assign load_value = ctrl_wdata;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[pio_pkg::CTRL_ENABLE] = enable;
        ctrl_word[pio_pkg::CTRL_KEEP_LSB +: pio_pkg::WORD_BYTES] = keep;
        ctrl_word[pio_pkg::CTRL_LAST] = last;
    end

    // status bit 0 is splitter ready
    assign stat_word = {{(pio_pkg::WORD_WIDTH - 1){1'b0}}, word_ready};

    always_comb begin
        ctrl_rdata = '0;
        if (ctrl_ren) begin
            case (ctrl_raddr[3:2])
                pio_pkg::REG_CTRL[3:2]:     ctrl_rdata = ctrl_word;
                pio_pkg::REG_DATA[3:2]:     ctrl_rdata = stat_word;
                pio_pkg::REG_DATA_CNT[3:2]: ctrl_rdata = data_cnt;
                pio_pkg::REG_NULL_CNT[3:2]: ctrl_rdata = null_cnt;
                default:                    ctrl_rdata = '0;
            endcase
        end
    end

endmodule

// File: verilog/pio_pkg.sv
package pio_pkg;

    // register port
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int WORD_BYTES = WORD_WIDTH / 8;
    localparam int WORD_SEL_WIDTH = $clog2(WORD_BYTES);

    // output stream, one byte per beat
    localparam int BEAT_BYTES = 1;
    localparam int BEAT_WIDTH = BEAT_BYTES * 8;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // register offsets
    localparam logic [ADDR_WIDTH-1:0] REG_CTRL = 32'h00;
    localparam logic [ADDR_WIDTH-1:0] REG_DATA = 32'h04;
    localparam logic [ADDR_WIDTH-1:0] REG_DATA_CNT = 32'h08;
    localparam logic [ADDR_WIDTH-1:0] REG_NULL_CNT = 32'h0C;

    // control register fields
    localparam int CTRL_ENABLE = 0;
    localparam int CTRL_CLEAR = 1;
    localparam int CTRL_KEEP_LSB = 4;
    localparam int CTRL_LAST = 8;
    localparam logic [WORD_WIDTH-1:0] CTRL_RESET_VALUE = 32'h0000_00F0;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] data;
        logic [WORD_BYTES-1:0] keep;
        logic                  last;
    } in_word_t;

    typedef struct packed {
        logic [BEAT_WIDTH-1:0] data;
        logic                  last;
    } out_beat_t;

endpackage
